/* src/rsa_pkg.sv */
`default_nettype none

package rsa_pkg;

    // array geometry
    localparam int RSA_ROWS = 4;
    localparam int RSA_COLS = 4;
    localparam int RSA_K    = 4;    // operand beats per run
    localparam int RSA_DW   = 16;

    localparam int BEAT_W = $clog2(RSA_K);
    localparam int COL_W  = $clog2(RSA_COLS);

    typedef logic [RSA_DW-1:0] data_t;

    // apb address map, byte addresses of 32-bit words
    localparam int APB_AW = 12;

    localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h004;
    localparam logic [APB_AW-1:0] ADDR_A_BASE = 12'h100;
    localparam logic [APB_AW-1:0] ADDR_B_BASE = 12'h200;
    localparam logic [APB_AW-1:0] ADDR_M_BASE = 12'h300;
    localparam logic [APB_AW-1:0] ADDR_C_BASE = 12'h400;

    // row adder opcode
    typedef enum logic {
        ADD_NONE = 1'b0,
        ADD_BIAS = 1'b1
    } add_mode_t;

    typedef enum logic [1:0] {
        FEED_IDLE,
        FEED_RUN,     // cal_en beats
        FEED_DRAIN    // single cal_done cycle
    } feed_state_t;

endpackage

`default_nettype wire

/* src/rsa_apb_regs.sv */
`default_nettype none

module rsa_apb_regs (
    input  wire                              clk,
    input  wire                              i_reset,
    input  wire                              i_psel,
    input  wire                              i_penable,
    input  wire                              i_pwrite,
    input  wire  [rsa_pkg::APB_AW-1:0]       i_paddr,
    input  wire  [31:0]                      i_pwdata,
    input  wire  [rsa_pkg::RSA_ROWS-1:0]     i_row_wr,
    input  wire  [rsa_pkg::COL_W-1:0]        i_row_col [rsa_pkg::RSA_ROWS],
    input  wire  rsa_pkg::data_t             i_row_data [rsa_pkg::RSA_ROWS],
    input  wire  [rsa_pkg::RSA_ROWS-1:0]     i_row_last,
    output logic [31:0]                      o_prdata,
    output logic                             o_pready,
    output logic                             o_pslverr,
    output logic                             o_start,
    output rsa_pkg::add_mode_t               o_mode,
    output rsa_pkg::data_t                   o_a [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_K],
    output rsa_pkg::data_t                   o_b [rsa_pkg::RSA_K][rsa_pkg::RSA_COLS],
    output rsa_pkg::data_t                   o_m [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS]
);

    rsa_pkg::data_t c_mem [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS];

    logic                          busy;
    logic                          done;    // sticky until next start
    logic [rsa_pkg::RSA_ROWS-1:0]  rows_fin;

    logic                          access;
    logic                          err;
    logic                          wr_en;
    logic                          ctrl_wr;
    logic                          in_tbl;
    logic [rsa_pkg::APB_AW-1:0]    region_base;
    logic [rsa_pkg::COL_W-1:0]     ent_row;
    logic [rsa_pkg::COL_W-1:0]     ent_col;

    assign access      = i_psel && i_penable;
    assign region_base = {i_paddr[rsa_pkg::APB_AW-1:8], 8'h00};
    assign in_tbl      = (i_paddr[7:6] == 2'b00) && (i_paddr[1:0] == 2'b00); // 16 words only
    assign ent_row     = i_paddr[5:4];
    assign ent_col     = i_paddr[3:2];

    assign wr_en   = access && i_pwrite && !err;
    assign ctrl_wr = wr_en && (region_base == rsa_pkg::ADDR_CTRL);

    assign o_pready  = access;    // no wait states
    assign o_pslverr = access && err;

    // address decode, read mux and error rules
    always_comb begin
        err      = 1'b0;
        o_prdata = '0;
        case (region_base)
            rsa_pkg::ADDR_CTRL: begin
                if (i_paddr == rsa_pkg::ADDR_CTRL) begin
                    o_prdata = {30'b0, o_mode == rsa_pkg::ADD_BIAS, 1'b0};
                    err      = i_pwrite && busy;
                end else if (i_paddr == rsa_pkg::ADDR_STATUS) begin
                    o_prdata = {30'b0, done, busy};
                    err      = i_pwrite;    // status is read only
                end else begin
                    err = 1'b1;
                end
            end
            rsa_pkg::ADDR_A_BASE: begin
                o_prdata = {16'h0, o_a[ent_row][ent_col]};
                err      = !in_tbl || (i_pwrite && busy);
            end
            rsa_pkg::ADDR_B_BASE: begin
                o_prdata = {16'h0, o_b[ent_row][ent_col]};
                err      = !in_tbl || (i_pwrite && busy);
            end
            rsa_pkg::ADDR_M_BASE: begin
                o_prdata = {16'h0, o_m[ent_row][ent_col]};
                err      = !in_tbl || (i_pwrite && busy);
            end
            rsa_pkg::ADDR_C_BASE: begin
                o_prdata = {16'h0, c_mem[ent_row][ent_col]};
                err      = !in_tbl || i_pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_start  <= 1'b0;
            o_mode   <= rsa_pkg::ADD_NONE;
            busy     <= 1'b0;
            done     <= 1'b0;
            rows_fin <= '0;
            for (int r = 0; r < rsa_pkg::RSA_ROWS; r++) begin
                for (int c = 0; c < rsa_pkg::RSA_COLS; c++) begin
                    o_a[r][c]   <= '0;
                    o_b[r][c]   <= '0;
                    o_m[r][c]   <= '0;
                    c_mem[r][c] <= '0;
                end
            end
        end else begin
            o_start <= ctrl_wr && i_pwdata[0];
            if (ctrl_wr) begin
                o_mode <= rsa_pkg::add_mode_t'(i_pwdata[1]);
                if (i_pwdata[0]) begin
                    busy     <= 1'b1;
                    done     <= 1'b0;
                    rows_fin <= '0;
                end
            end else if (busy) begin
                rows_fin <= rows_fin | i_row_last;
                if (&(rows_fin | i_row_last)) begin    // last row just drained
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end

            if (wr_en) begin
                case (region_base)
                    rsa_pkg::ADDR_A_BASE: o_a[ent_row][ent_col] <= i_pwdata[rsa_pkg::RSA_DW-1:0];
                    rsa_pkg::ADDR_B_BASE: o_b[ent_row][ent_col] <= i_pwdata[rsa_pkg::RSA_DW-1:0];
                    rsa_pkg::ADDR_M_BASE: o_m[ent_row][ent_col] <= i_pwdata[rsa_pkg::RSA_DW-1:0];
                    default: ;    // ctrl handled above
                endcase
            end

            // results from the row adders
            for (int r = 0; r < rsa_pkg::RSA_ROWS; r++) begin
                if (i_row_wr[r]) begin
                    c_mem[r][i_row_col[r]] <= i_row_data[r];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/rsa_feeder.sv */
`default_nettype none

module rsa_feeder (
    input  wire                  clk,
    input  wire                  i_reset,
    input  wire                  i_start,
    input  wire rsa_pkg::data_t  i_a [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_K],
    input  wire rsa_pkg::data_t  i_b [rsa_pkg::RSA_K][rsa_pkg::RSA_COLS],
    output wire rsa_pkg::data_t  o_west [rsa_pkg::RSA_ROWS],
    output wire rsa_pkg::data_t  o_south [rsa_pkg::RSA_COLS],
    output logic                 o_cal_en,
    output logic                 o_cal_done
);

    rsa_pkg::feed_state_t         state;
    logic [rsa_pkg::BEAT_W-1:0]   beat_cnt;
    logic                         feeding;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state    <= rsa_pkg::FEED_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                rsa_pkg::FEED_IDLE: begin
                    beat_cnt <= '0;
                    if (i_start) state <= rsa_pkg::FEED_RUN;
                end
                rsa_pkg::FEED_RUN: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (beat_cnt == rsa_pkg::RSA_K - 1) state <= rsa_pkg::FEED_DRAIN;
                end
                rsa_pkg::FEED_DRAIN: state <= rsa_pkg::FEED_IDLE;
                default: state <= rsa_pkg::FEED_IDLE;
            endcase
        end
    end

    assign feeding    = (state == rsa_pkg::FEED_RUN);
    assign o_cal_en   = feeding;
    assign o_cal_done = (state == rsa_pkg::FEED_DRAIN);    // one cycle after last beat

    // square array, so lane i is row i for A and column i for B
    for (genvar i = 0; i < rsa_pkg::RSA_ROWS; i++) begin : g_lane
        rsa_pkg::data_t a_beat;
        rsa_pkg::data_t b_beat;

        assign a_beat = feeding ? i_a[i][beat_cnt] : '0;
        assign b_beat = feeding ? i_b[beat_cnt][i] : '0;

        if (i == 0) begin : g_direct
            assign o_west[i]  = a_beat;
            assign o_south[i] = b_beat;
        end else begin : g_skew
            rsa_pkg::data_t a_dly [i];    // depth i gives i cycles of skew
            rsa_pkg::data_t b_dly [i];

            always_ff @(posedge clk) begin
                if (i_reset) begin
                    for (int d = 0; d < i; d++) begin
                        a_dly[d] <= '0;
                        b_dly[d] <= '0;
                    end
                end else begin
                    a_dly[0] <= a_beat;
                    b_dly[0] <= b_beat;
                    for (int d = 1; d < i; d++) begin
                        a_dly[d] <= a_dly[d-1];
                        b_dly[d] <= b_dly[d-1];
                    end
                end
            end

            assign o_west[i]  = a_dly[i-1];
            assign o_south[i] = b_dly[i-1];
        end
    end

endmodule

`default_nettype wire

/* src/pe_mac.sv */
`default_nettype none

module pe_mac (
    input  wire                  clk,
    input  wire                  i_reset,
    input  wire                  i_cal_en,
    input  wire                  i_cal_done,
    input  wire rsa_pkg::data_t  i_westin,
    input  wire rsa_pkg::data_t  i_southin,
    input  wire                  i_din_val,     // drain from east neighbor
    input  wire rsa_pkg::data_t  i_din,
    output logic                 o_n_cal_en,
    output logic                 o_n_cal_done,
    output rsa_pkg::data_t       o_eastout,
    output rsa_pkg::data_t       o_northout,
    output logic                 o_dout_val,
    output rsa_pkg::data_t       o_dout
);

    rsa_pkg::data_t acc;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_n_cal_en   <= 1'b0;
            o_n_cal_done <= 1'b0;
            o_dout_val   <= 1'b0;
            acc          <= '0;
        end else begin
            o_n_cal_en   <= i_cal_en;
            o_n_cal_done <= i_cal_done;
            if (i_cal_done) begin
                o_dout_val <= 1'b1;
                acc        <= '0;    // ready for next run
            end else begin
                o_dout_val <= i_din_val;
                if (i_cal_en) acc <= acc + i_westin * i_southin;    // wraps mod 2^16
            end
        end
    end

    // operand pass-through and drain word
    always_ff @(posedge clk) begin
        o_eastout  <= i_westin;
        o_northout <= i_southin;
        o_dout     <= i_cal_done ? acc : i_din;
    end

endmodule

`default_nettype wire

/* src/pe_array.sv */
`default_nettype none

module pe_array (
    input  wire                            clk,
    input  wire                            i_reset,
    input  wire rsa_pkg::data_t            i_west [rsa_pkg::RSA_ROWS],
    input  wire rsa_pkg::data_t            i_south [rsa_pkg::RSA_COLS],
    input  wire                            i_cal_en,
    input  wire                            i_cal_done,
    output wire [rsa_pkg::RSA_ROWS-1:0]    o_dout_val,
    output wire rsa_pkg::data_t            o_dout [rsa_pkg::RSA_ROWS]
);

    // [r][c] is the input side of PE(r,c), the extra index is the far edge
    wire rsa_pkg::data_t  east_bus [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS+1];
    wire rsa_pkg::data_t  north_bus [rsa_pkg::RSA_ROWS+1][rsa_pkg::RSA_COLS];
    wire                  dval_bus [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS+1];
    wire rsa_pkg::data_t  dout_bus [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS+1];
    wire                  en_q [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS];
    wire                  done_q [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS];

    for (genvar r = 0; r < rsa_pkg::RSA_ROWS; r++) begin : g_edge_row
        assign east_bus[r][0]                 = i_west[r];
        assign dval_bus[r][rsa_pkg::RSA_COLS] = 1'b0;    // nothing east of last column
        assign dout_bus[r][rsa_pkg::RSA_COLS] = '0;
        assign o_dout_val[r]                  = dval_bus[r][0];
        assign o_dout[r]                      = dout_bus[r][0];
    end

    for (genvar c = 0; c < rsa_pkg::RSA_COLS; c++) begin : g_edge_col
        assign north_bus[0][c] = i_south[c];
    end

    for (genvar r = 0; r < rsa_pkg::RSA_ROWS; r++) begin : g_row
        for (genvar c = 0; c < rsa_pkg::RSA_COLS; c++) begin : g_col
            wire pe_en;
            wire pe_done;

            // strobes go east along row 0, then north up each column
            if (r == 0 && c == 0) begin : g_entry
                assign pe_en   = i_cal_en;
                assign pe_done = i_cal_done;
            end else if (r == 0) begin : g_from_west
                assign pe_en   = en_q[0][c-1];
                assign pe_done = done_q[0][c-1];
            end else begin : g_from_south
                assign pe_en   = en_q[r-1][c];
                assign pe_done = done_q[r-1][c];
            end

            pe_mac pe_i (
                .clk          (clk),
                .i_reset      (i_reset),
                .i_cal_en     (pe_en),
                .i_cal_done   (pe_done),
                .i_westin     (east_bus[r][c]),
                .i_southin    (north_bus[r][c]),
                .i_din_val    (dval_bus[r][c+1]),
                .i_din        (dout_bus[r][c+1]),
                .o_n_cal_en   (en_q[r][c]),
                .o_n_cal_done (done_q[r][c]),
                .o_eastout    (east_bus[r][c+1]),
                .o_northout   (north_bus[r+1][c]),
                .o_dout_val   (dval_bus[r][c]),
                .o_dout       (dout_bus[r][c])
            );
        end
    end

endmodule

`default_nettype wire

/* src/row_adder.sv */
`default_nettype none

module row_adder (
    input  wire                           clk,
    input  wire                           i_reset,
    input  wire rsa_pkg::add_mode_t       i_mode,
    input  wire rsa_pkg::data_t           i_m [rsa_pkg::RSA_COLS],
    input  wire                           i_val,
    input  wire rsa_pkg::data_t           i_data,
    output logic                          o_wr,
    output logic [rsa_pkg::COL_W-1:0]     o_col,
    output rsa_pkg::data_t                o_data,
    output logic                          o_last
);

    logic [rsa_pkg::COL_W-1:0] col_cnt;    // words arrive in column order

    always_ff @(posedge clk) begin
        if (i_reset) begin
            col_cnt <= '0;
            o_wr    <= 1'b0;
            o_last  <= 1'b0;
        end else begin
            o_wr   <= i_val;
            o_last <= i_val && (col_cnt == rsa_pkg::RSA_COLS - 1);
            if (i_val) col_cnt <= col_cnt + 1'b1;    // wraps back to 0 for next run
        end
    end

    always_ff @(posedge clk) begin
        if (i_val) begin
            o_col  <= col_cnt;
            o_data <= (i_mode == rsa_pkg::ADD_BIAS) ? i_data + i_m[col_cnt] : i_data;
        end
    end

endmodule

`default_nettype wire

/* src/rsa_top.sv */
`default_nettype none

module rsa_top (
    input  wire                          clk,
    input  wire                          i_reset,
    input  wire                          i_psel,
    input  wire                          i_penable,
    input  wire                          i_pwrite,
    input  wire [rsa_pkg::APB_AW-1:0]    i_paddr,
    input  wire [31:0]                   i_pwdata,
    output wire [31:0]                   o_prdata,
    output wire                          o_pready,
    output wire                          o_pslverr
);

    wire                         start;
    rsa_pkg::add_mode_t          mode;
    wire rsa_pkg::data_t         a_mem [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_K];
    wire rsa_pkg::data_t         b_mem [rsa_pkg::RSA_K][rsa_pkg::RSA_COLS];
    wire rsa_pkg::data_t         m_mem [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS];

    wire rsa_pkg::data_t         west [rsa_pkg::RSA_ROWS];
    wire rsa_pkg::data_t         south [rsa_pkg::RSA_COLS];
    wire                         cal_en;
    wire                         cal_done;

    wire [rsa_pkg::RSA_ROWS-1:0] drain_val;
    wire rsa_pkg::data_t         drain_data [rsa_pkg::RSA_ROWS];

    wire [rsa_pkg::RSA_ROWS-1:0] row_wr;
    wire [rsa_pkg::COL_W-1:0]    row_col [rsa_pkg::RSA_ROWS];
    wire rsa_pkg::data_t         row_data [rsa_pkg::RSA_ROWS];
    wire [rsa_pkg::RSA_ROWS-1:0] row_last;

    rsa_apb_regs regs_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_psel     (i_psel),
        .i_penable  (i_penable),
        .i_pwrite   (i_pwrite),
        .i_paddr    (i_paddr),
        .i_pwdata   (i_pwdata),
        .i_row_wr   (row_wr),
        .i_row_col  (row_col),
        .i_row_data (row_data),
        .i_row_last (row_last),
        .o_prdata   (o_prdata),
        .o_pready   (o_pready),
        .o_pslverr  (o_pslverr),
        .o_start    (start),
        .o_mode     (mode),
        .o_a        (a_mem),
        .o_b        (b_mem),
        .o_m        (m_mem)
    );

    rsa_feeder feeder_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_start    (start),
        .i_a        (a_mem),
        .i_b        (b_mem),
        .o_west     (west),
        .o_south    (south),
        .o_cal_en   (cal_en),
        .o_cal_done (cal_done)
    );

    pe_array array_i (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_west     (west),
        .i_south    (south),
        .i_cal_en   (cal_en),
        .i_cal_done (cal_done),
        .o_dout_val (drain_val),
        .o_dout     (drain_data)
    );

    // one bias adder per row on the west drain
    for (genvar r = 0; r < rsa_pkg::RSA_ROWS; r++) begin : g_adder
        row_adder adder_i (
            .clk     (clk),
            .i_reset (i_reset),
            .i_mode  (mode),
            .i_m     (m_mem[r]),
            .i_val   (drain_val[r]),
            .i_data  (drain_data[r]),
            .o_wr    (row_wr[r]),
            .o_col   (row_col[r]),
            .o_data  (row_data[r]),
            .o_last  (row_last[r])
        );
    end

endmodule

`default_nettype wire

/* test/rsa_tb.sv */
`default_nettype none

module rsa_tb;

    localparam int READY_LIMIT = 8;      // cycles allowed for pready
    localparam int DONE_POLLS  = 100;    // status reads before giving up

    logic                        clk;
    logic                        reset;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [rsa_pkg::APB_AW-1:0]  paddr;
    logic [31:0]                 pwdata;
    wire  [31:0]                 prdata;
    wire                         pready;
    wire                         pslverr;

    // operand copies for the reference model
    rsa_pkg::data_t a_ref [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_K];
    rsa_pkg::data_t b_ref [rsa_pkg::RSA_K][rsa_pkg::RSA_COLS];
    rsa_pkg::data_t m_ref [rsa_pkg::RSA_ROWS][rsa_pkg::RSA_COLS];
    logic [31:0]    rng_state;

    logic [31:0]    rdata;
    logic           err;

    rsa_top dut_i (
        .clk       (clk),
        .i_reset   (reset),
        .i_psel    (psel),
        .i_penable (penable),
        .i_pwrite  (pwrite),
        .i_paddr   (paddr),
        .i_pwdata  (pwdata),
        .o_prdata  (prdata),
        .o_pready  (pready),
        .o_pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // C(r,c) is the sum over k of A(r,k)*B(k,c) plus M(r,c) in bias mode, mod 2^16
    function automatic rsa_pkg::data_t expected_c(input int r, input int c, input logic bias);
        rsa_pkg::data_t sum;
        sum = '0;
        for (int k = 0; k < rsa_pkg::RSA_K; k++) begin
            sum = sum + a_ref[r][k] * b_ref[k][c];
        end
        if (bias) sum = sum + m_ref[r][c];
        return sum;
    endfunction

    function automatic logic [rsa_pkg::APB_AW-1:0] entry_addr(
        input logic [rsa_pkg::APB_AW-1:0] base,
        input int row,
        input int col
    );
        int offset;
        offset = 4 * (row * 4 + col);    // 4 words per row
        return base + offset[rsa_pkg::APB_AW-1:0];
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    // one apb transfer with setup and access phases
    task automatic do_transfer(
        input  logic                       write,
        input  logic [rsa_pkg::APB_AW-1:0] addr,
        input  logic [31:0]                wdata,
        output logic [31:0]                data,
        output logic                       slverr
    );
        int waited;
        waited = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        while (!pready) begin
            if (waited >= READY_LIMIT) begin
                abort_run("apb transfer never saw pready");
            end
            waited++;
            @(posedge clk);
        end
        data   = prdata;
        slverr = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(
        input  logic [rsa_pkg::APB_AW-1:0] addr,
        input  logic [31:0]                data,
        output logic                       slverr
    );
        logic [31:0] unused;
        do_transfer(1'b1, addr, data, unused, slverr);
    endtask

    task automatic read_reg(
        input  logic [rsa_pkg::APB_AW-1:0] addr,
        output logic [31:0]                data,
        output logic                       slverr
    );
        do_transfer(1'b0, addr, 32'h0, data, slverr);
    endtask

    task automatic write_checked(input logic [rsa_pkg::APB_AW-1:0] addr, input logic [31:0] data);
        logic slverr;
        write_reg(addr, data, slverr);
        check_equal("pslverr", {31'b0, slverr}, 32'h0);
    endtask

    task automatic read_checked(
        input string                      name,
        input logic [rsa_pkg::APB_AW-1:0] addr,
        input logic [31:0]                exp
    );
        logic [31:0] data;
        logic        slverr;
        read_reg(addr, data, slverr);
        check_equal("pslverr", {31'b0, slverr}, 32'h0);
        check_equal(name, data, exp);
    endtask

    // fresh random A, B and M with random upper bits in each word
    task automatic load_operands();
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                rng_state = xorshift32(rng_state);
                a_ref[r][c] = rng_state[15:0];
                write_checked(entry_addr(rsa_pkg::ADDR_A_BASE, r, c), rng_state);
                rng_state = xorshift32(rng_state);
                b_ref[r][c] = rng_state[15:0];
                write_checked(entry_addr(rsa_pkg::ADDR_B_BASE, r, c), rng_state);
                rng_state = xorshift32(rng_state);
                m_ref[r][c] = rng_state[15:0];
                write_checked(entry_addr(rsa_pkg::ADDR_M_BASE, r, c), rng_state);
            end
        end
    endtask

    task automatic start_run(input logic bias);
        write_checked(rsa_pkg::ADDR_CTRL, {30'b0, bias, 1'b1});
    endtask

    task automatic wait_for_done();
        logic [31:0] status;
        logic        slverr;
        int          polls;
        polls = 0;
        read_reg(rsa_pkg::ADDR_STATUS, status, slverr);
        check_equal("pslverr", {31'b0, slverr}, 32'h0);
        while (!status[1]) begin
            if (polls >= DONE_POLLS) begin
                abort_run("run did not finish in time");
            end
            polls++;
            read_reg(rsa_pkg::ADDR_STATUS, status, slverr);
            check_equal("pslverr", {31'b0, slverr}, 32'h0);
        end
        check_equal("status", status, 32'h2);    // done set and busy clear
    endtask

    task automatic check_results(input logic bias);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                read_checked($sformatf("c[%0d][%0d]", r, c),
                             entry_addr(rsa_pkg::ADDR_C_BASE, r, c),
                             {16'h0, expected_c(r, c, bias)});
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        rng_state = 32'h8530;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // reset state
        read_checked("status", rsa_pkg::ADDR_STATUS, 32'h0);
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                read_checked("c after reset", entry_addr(rsa_pkg::ADDR_C_BASE, r, c), 32'h0);
            end
        end

        // plain product with M loaded but ignored
        load_operands();
        start_run(1'b0);
        wait_for_done();
        check_results(1'b0);

        // product plus bias
        load_operands();
        start_run(1'b1);
        wait_for_done();
        check_results(1'b1);

        // slave errors
        read_reg(12'h500, rdata, err);
        check_equal("pslverr unmapped", {31'b0, err}, 32'h1);
        read_reg(12'h140, rdata, err);    // past the 16 A words
        check_equal("pslverr unmapped", {31'b0, err}, 32'h1);
        write_reg(entry_addr(rsa_pkg::ADDR_C_BASE, 0, 0), 32'h1234, err);
        check_equal("pslverr c write", {31'b0, err}, 32'h1);
        read_checked("c[0][0]", entry_addr(rsa_pkg::ADDR_C_BASE, 0, 0),
                     {16'h0, expected_c(0, 0, 1'b1)});

        start_run(1'b1);
        read_checked("status", rsa_pkg::ADDR_STATUS, 32'h1);
        write_reg(entry_addr(rsa_pkg::ADDR_A_BASE, 0, 0), {16'h0, ~a_ref[0][0]}, err);
        check_equal("pslverr busy write", {31'b0, err}, 32'h1);
        wait_for_done();
        read_checked("a[0][0]", entry_addr(rsa_pkg::ADDR_A_BASE, 0, 0), {16'h0, a_ref[0][0]});
        check_results(1'b1);

        // back to back runs from cleared accumulators
        for (int run = 0; run < 2; run++) begin
            load_operands();
            start_run(run[0]);
            wait_for_done();
            check_results(run[0]);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* rsa_top.f */
src/rsa_pkg.sv
src/rsa_apb_regs.sv
src/rsa_feeder.sv
src/pe_mac.sv
src/pe_array.sv
src/row_adder.sv
src/rsa_top.sv
test/rsa_tb.sv

/* Bender.yml */
package:
  name: rsa

sources:
  - src/rsa_pkg.sv
  - src/rsa_apb_regs.sv
  - src/rsa_feeder.sv
  - src/pe_mac.sv
  - src/pe_array.sv
  - src/row_adder.sv
  - src/rsa_top.sv
  - target: test
    files:
      - test/rsa_tb.sv
